// File: common/audio_params.svh
`ifndef AUDIO_PARAMS_SVH
`define AUDIO_PARAMS_SVH

//////////////////////////////////////////////////
// audio datapath widths
//////////////////////////////////////////////////

// widest I2S slot word accepted
`define SLOT_W 32

// output sample width after alignment
`define PCM_W 24

// duty resolution, period is 2**PWM_W clocks
`define PWM_W 8

// frame store entries, also the credit count
`define CREDIT_DEPTH 2

`endif

// File: common/audio_pkg.sv
`include "audio_params.svh"

package audio_pkg;

    // enough bits to hold a slot length of 0 to SLOT_W
    localparam int SLOT_LEN_W = $clog2(`SLOT_W + 1);

    //////////////////////////////////////////////////
    // pcm word views
    //////////////////////////////////////////////////

    // sign, upper magnitude bits, then the residue dropped by the modulator
    typedef struct packed {
        logic                      sign;
        logic [`PWM_W-2:0]         mag_hi;
        logic [`PCM_W-`PWM_W-1:0]  residue;
    } pcm_pwm_view_t;

    // one sample word, read as two's complement or as pwm fields
    typedef union packed {
        logic signed [`PCM_W-1:0]  sample;
        pcm_pwm_view_t             pwm;
    } pcm_word_u;

    // stereo frame, left in the upper half
    typedef struct packed {
        pcm_word_u  left;
        pcm_word_u  right;
    } pcm_frame_t;

    //////////////////////////////////////////////////
    // receiver side
    //////////////////////////////////////////////////

    // raw slot as captured, right aligned in word
    typedef struct packed {
        logic [`SLOT_W-1:0]     word;
        logic [SLOT_LEN_W-1:0]  len;
        // 0 for left slot
        logic                   chan;
    } slot_cap_t;

    typedef struct packed {
        logic                   overrun;
        logic [SLOT_LEN_W-1:0]  last_len;
    } rx_status_t;

endpackage

// File: i2s_rx/i2s_rx.sv
`include "audio_params.svh"

module i2s_rx
    import audio_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       bclk,
    input  logic       lrclk,
    input  logic       sdata,
    output logic       slot_valid,
    output slot_cap_t  slot
);

    // bclk sync chain, oldest in bit 2
    logic [2:0] bclk_sync;
    logic [1:0] lrclk_sync;
    logic [1:0] sdata_sync;
    // one clk pulse per bclk rising edge
    logic       bclk_rise;

    // lrclk as sampled on the last two bclk edges
    logic       lr_d1;
    logic       lr_d2;
    logic       lr_change;

    logic [`SLOT_W-1:0]    shift_reg;
    logic [SLOT_LEN_W-1:0] bit_cnt;

    //////////////////////////////////////////////////
    // pin synchronizers
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bclk_sync  <= '0;
            lrclk_sync <= '0;
            sdata_sync <= '0;
            bclk_rise  <= 1'b0;
        end else begin
            bclk_sync  <= {bclk_sync[1:0], bclk};
            lrclk_sync <= {lrclk_sync[0], lrclk};
            sdata_sync <= {sdata_sync[0], sdata};
            // registered edge, visible 3 clk after the pin
            bclk_rise  <= bclk_sync[1] & ~bclk_sync[2];
        end
    end

    //////////////////////////////////////////////////
    // slot shifter
    //////////////////////////////////////////////////

    // lrclk moved one bclk ago
    // the I2S delay bit has been shifted in by now
    assign lr_change = lr_d1 != lr_d2;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lr_d1      <= 1'b0;
            lr_d2      <= 1'b0;
            shift_reg  <= '0;
            bit_cnt    <= '0;
            slot_valid <= 1'b0;
            slot       <= '0;
        end else begin
            slot_valid <= 1'b0;
            if (bclk_rise) begin
                lr_d1 <= lrclk_sync[1];
                lr_d2 <= lr_d1;
                if (lr_change) begin
                    // hand off the finished slot
                    slot_valid <= 1'b1;
                    slot.word  <= shift_reg;
                    slot.len   <= bit_cnt;
                    slot.chan  <= lr_d2;
                    // current bit is the msb of the new slot
                    shift_reg  <= {{(`SLOT_W-1){1'b0}}, sdata_sync[1]};
                    bit_cnt    <= SLOT_LEN_W'(1);
                end else if (bit_cnt < SLOT_LEN_W'(`SLOT_W)) begin
                    shift_reg <= {shift_reg[`SLOT_W-2:0], sdata_sync[1]};
                    bit_cnt   <= bit_cnt + 1'b1;
                end
                // past SLOT_W bits the msbs are kept and the count clamps
            end
        end
    end

endmodule

// File: i2s_rx/sample_aligner.sv
`include "audio_params.svh"

module sample_aligner
    import audio_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        slot_valid,
    input  slot_cap_t   slot,
    input  logic        credit_return,
    output logic        frame_valid,
    output pcm_frame_t  frame,
    output rx_status_t  status
);

    localparam int CRED_W = $clog2(`CREDIT_DEPTH + 1);

    logic [SLOT_LEN_W-1:0] shift_amt;
    logic [`SLOT_W-1:0]    justified;
    pcm_word_u             aligned;
    pcm_word_u             left_hold;
    logic [CRED_W-1:0]     credits;
    logic                  right_done;
    logic                  issue;

    //////////////////////////////////////////////////
    // barrel shift
    //////////////////////////////////////////////////

    // move the msb up to bit SLOT_W-1, short slots get zero fill
    always_comb begin
        shift_amt      = SLOT_LEN_W'(`SLOT_W) - slot.len;
        justified      = slot.word << shift_amt;
        aligned.sample = justified[`SLOT_W-1 -: `PCM_W];
    end

    // left sample waits here for its right partner
    always_ff @(posedge clk) begin
        if (slot_valid && !slot.chan) begin
            left_hold <= aligned;
        end
        if (issue) begin
            frame.left  <= left_hold;
            frame.right <= aligned;
        end
    end

    //////////////////////////////////////////////////
    // credits and status
    //////////////////////////////////////////////////

    assign right_done = slot_valid & slot.chan;
    assign issue      = right_done & (credits != '0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            credits     <= CRED_W'(`CREDIT_DEPTH);
            frame_valid <= 1'b0;
            status      <= '0;
        end else begin
            credits     <= credits - CRED_W'(issue) + CRED_W'(credit_return);
            frame_valid <= issue;
            // no credit means the frame is lost
            if (right_done && (credits == '0)) begin
                status.overrun <= 1'b1;
            end
            if (slot_valid) begin
                status.last_len <= slot.len;
            end
        end
    end

endmodule

// File: pwm/pwm_modulator.sv
`include "audio_params.svh"

module pwm_modulator
    import audio_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        frame_valid,
    input  pcm_frame_t  frame,
    output logic        credit_return,
    output logic        pwm_l,
    output logic        pwm_r
);

    localparam int PTR_W = $clog2(`CREDIT_DEPTH);
    localparam int CNT_W = $clog2(`CREDIT_DEPTH + 1);

    pcm_frame_t         store [`CREDIT_DEPTH];
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [CNT_W-1:0]   fill;
    logic               push;
    logic               pop;

    logic [`PWM_W-1:0]  period_cnt;
    logic [`PWM_W-1:0]  duty_l;
    logic [`PWM_W-1:0]  duty_r;
    logic               wrap;

    // offset binary code from sign and upper magnitude
    function automatic logic [`PWM_W-1:0] duty_code(pcm_word_u w);
        return {~w.pwm.sign, w.pwm.mag_hi};
    endfunction

    //////////////////////////////////////////////////
    // frame store
    //////////////////////////////////////////////////

    assign wrap = period_cnt == '1;
    // the aligner only sends with a credit in hand
    assign push = frame_valid && (fill != CNT_W'(`CREDIT_DEPTH));
    assign pop  = wrap && (fill != '0);

    always_ff @(posedge clk) begin
        if (push) begin
            store[wr_ptr] <= frame;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr        <= '0;
            rd_ptr        <= '0;
            fill          <= '0;
            credit_return <= 1'b0;
            period_cnt    <= '0;
            duty_l        <= '0;
            duty_r        <= '0;
        end else begin
            period_cnt    <= period_cnt + 1'b1;
            credit_return <= pop;
            fill          <= fill + CNT_W'(push) - CNT_W'(pop);
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(`CREDIT_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            // new duty lands as the counter rolls to 0
            if (pop) begin
                duty_l <= duty_code(store[rd_ptr].left);
                duty_r <= duty_code(store[rd_ptr].right);
                rd_ptr <= (rd_ptr == PTR_W'(`CREDIT_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////
    // comparators
    //////////////////////////////////////////////////

    // high for duty clocks, duty 0 never high
    assign pwm_l = period_cnt < duty_l;
    assign pwm_r = period_cnt < duty_r;

endmodule

// File: src/i2s_pwm_top.sv
module i2s_pwm_top
    import audio_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        bclk,
    input  logic        lrclk,
    input  logic        sdata,
    output logic        pwm_l,
    output logic        pwm_r,
    output logic        pcm_valid,
    output pcm_frame_t  pcm,
    output rx_status_t  status
);

    // receiver to aligner
    logic       slot_valid;
    slot_cap_t  slot;
    // modulator back to aligner
    logic       credit_return;

    i2s_rx u_i2s_rx (
        .clk        (clk),
        .rst_n      (rst_n),
        .bclk       (bclk),
        .lrclk      (lrclk),
        .sdata      (sdata),
        .slot_valid (slot_valid),
        .slot       (slot)
    );

    // aligned frames also leave the top as pcm
    sample_aligner u_sample_aligner (
        .clk           (clk),
        .rst_n         (rst_n),
        .slot_valid    (slot_valid),
        .slot          (slot),
        .credit_return (credit_return),
        .frame_valid   (pcm_valid),
        .frame         (pcm),
        .status        (status)
    );

    pwm_modulator u_pwm_modulator (
        .clk           (clk),
        .rst_n         (rst_n),
        .frame_valid   (pcm_valid),
        .frame         (pcm),
        .credit_return (credit_return),
        .pwm_l         (pwm_l),
        .pwm_r         (pwm_r)
    );

endmodule

// File: tests/i2s_pwm_sva.sv
`include "audio_params.svh"

// bound into the aligner and into the modulator
module i2s_pwm_sva (
    input logic       clk,
    input logic       rst_n,
    // incoming frame or credit that needs room here
    input logic       send,
    input logic       strobe,
    // room left for an incoming send
    input logic [1:0] credits,
    // outputs that sit low in reset
    input logic [1:0] pins
);

    // room never past the depth
    a_credit_range: assert property (@(posedge clk) disable iff (!rst_n)
        credits <= 2'(`CREDIT_DEPTH))
        else $error("credit count out of range");

    a_send_credit: assert property (@(posedge clk) disable iff (!rst_n)
        send |-> credits != '0)
        else $error("frame or credit arrived with no room");

    // strobes last one clk
    a_strobe_single: assert property (@(posedge clk) disable iff (!rst_n)
        strobe |=> !strobe)
        else $error("strobe held longer than one cycle");

    a_pins_reset: assert property (@(posedge clk)
        !rst_n |-> pins == 2'b00)
        else $error("output high during reset");

endmodule

bind sample_aligner i2s_pwm_sva u_aligner_sva (
    .clk     (clk),
    .rst_n   (rst_n),
    // a returned credit needs one handed out
    .send    (credit_return),
    .strobe  (slot_valid),
    .credits (2'(`CREDIT_DEPTH) - credits),
    .pins    ({frame_valid, status.overrun})
);

bind pwm_modulator i2s_pwm_sva u_modulator_sva (
    .clk     (clk),
    .rst_n   (rst_n),
    // a frame needs a free store entry
    .send    (frame_valid),
    .strobe  (frame_valid),
    .credits (2'(`CREDIT_DEPTH) - fill),
    .pins    ({pwm_l, pwm_r})
);

// File: tests/tb_i2s_pwm.sv
`include "audio_params.svh"

module tb_i2s_pwm
    import audio_pkg::*;
();

    localparam int MAX_FRAMES  = 64;
    localparam int HALF_BCLK   = 4;
    localparam int PERIOD_CLKS = 1 << `PWM_W;
    localparam int MARGIN      = 4096;

    logic        clk;
    logic        rst_n;
    logic        bclk;
    logic        lrclk;
    logic        sdata;
    logic        pwm_l;
    logic        pwm_r;
    logic        pcm_valid;
    pcm_frame_t  pcm;
    rx_status_t  status;

    // golden frames
    logic [SLOT_LEN_W-1:0] g_len       [MAX_FRAMES];
    logic [`SLOT_W-1:0]    g_left_raw  [MAX_FRAMES];
    logic [`SLOT_W-1:0]    g_right_raw [MAX_FRAMES];
    pcm_frame_t            g_frame     [MAX_FRAMES];
    logic [`PWM_W-1:0]     g_duty_l    [MAX_FRAMES];
    logic [`PWM_W-1:0]     g_duty_r    [MAX_FRAMES];
    int                    n_frames;

    // one entry per bclk period, lrclk and data before the I2S delay
    bit lr_stream[$];
    bit d_stream[$];

    // monitor state
    logic [2*`PWM_W-1:0] duty_q[$];
    logic [2*`PWM_W-1:0] duty_exp;
    int  frames_seen;
    int  duties_done;
    bit  in_window;
    int  win_cnt;
    int  high_l;
    int  high_r;
    int  cycle_cnt;
    int  cycle_limit;

    i2s_pwm_top UUT (
        .clk       (clk),
        .rst_n     (rst_n),
        .bclk      (bclk),
        .lrclk     (lrclk),
        .sdata     (sdata),
        .pwm_l     (pwm_l),
        .pwm_r     (pwm_r),
        .pcm_valid (pcm_valid),
        .pcm       (pcm),
        .status    (status)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    //////////////////////////////////////////////////
    // failure and compare tasks
    //////////////////////////////////////////////////

    task automatic stop_with_failure(string why);
        $display("%s", why);
        $display("Regression failed");
        $fatal(1);
    endtask

    task automatic check_level(string name, logic got, logic exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("error %s: got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_frame(int idx, pcm_frame_t got, pcm_frame_t exp);
        if (got.left.sample !== exp.left.sample) begin
            stop_with_failure($sformatf("error pcm.left frame %0d: got %h expected %h",
                idx, got.left.sample, exp.left.sample));
        end
        if (got.right.sample !== exp.right.sample) begin
            stop_with_failure($sformatf("error pcm.right frame %0d: got %h expected %h",
                idx, got.right.sample, exp.right.sample));
        end
    endtask

    task automatic check_status(rx_status_t got, rx_status_t exp);
        if (got.overrun !== exp.overrun) begin
            stop_with_failure($sformatf("error status.overrun: got %h expected %h",
                got.overrun, exp.overrun));
        end
        if (got.last_len !== exp.last_len) begin
            stop_with_failure($sformatf("error status.last_len: got %h expected %h",
                got.last_len, exp.last_len));
        end
    endtask

    // high clocks over one whole period against the duty code
    task automatic check_duty(int idx, logic [`PWM_W-1:0] exp_l, logic [`PWM_W-1:0] exp_r,
                              int hi_l, int hi_r);
        if (hi_l != int'(exp_l)) begin
            stop_with_failure($sformatf("error pwm_l duty frame %0d: got %h expected %h",
                idx, hi_l, exp_l));
        end
        if (hi_r != int'(exp_r)) begin
            stop_with_failure($sformatf("error pwm_r duty frame %0d: got %h expected %h",
                idx, hi_r, exp_r));
        end
    endtask

    //////////////////////////////////////////////////
    // golden file and i2s stimulus
    //////////////////////////////////////////////////

    task automatic load_golden();
        int fd;
        int n;
        string line;
        logic [31:0] len_v;
        logic [31:0] lraw;
        logic [31:0] rraw;
        logic [31:0] lpcm;
        logic [31:0] rpcm;
        logic [31:0] dl;
        logic [31:0] dr;
        fd = $fopen("tests/i2s_pwm_golden.txt", "r");
        if (fd == 0) begin
            stop_with_failure("could not open the golden file tests/i2s_pwm_golden.txt");
        end
        n_frames = 0;
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            // skip blanks and comment lines
            if (line.len() > 1 && line[0] != "#") begin
                n = $sscanf(line, "%h %h %h %h %h %h %h", len_v, lraw, rraw, lpcm, rpcm, dl, dr);
                if (n == 7 && n_frames < MAX_FRAMES) begin
                    g_len[n_frames]       = len_v[SLOT_LEN_W-1:0];
                    g_left_raw[n_frames]  = lraw;
                    g_right_raw[n_frames] = rraw;
                    g_frame[n_frames]     = {lpcm[`PCM_W-1:0], rpcm[`PCM_W-1:0]};
                    g_duty_l[n_frames]    = dl[`PWM_W-1:0];
                    g_duty_r[n_frames]    = dr[`PWM_W-1:0];
                    n_frames++;
                end
            end
        end
        $fclose(fd);
        if (n_frames == 0) begin
            stop_with_failure("the golden file holds no frames");
        end
    endtask

    // left slot then right slot, msb first, low len bits of each word
    task automatic build_stream();
        int f;
        int i;
        for (f = 0; f < n_frames; f++) begin
            for (i = int'(g_len[f]) - 1; i >= 0; i--) begin
                lr_stream.push_back(1'b0);
                d_stream.push_back(g_left_raw[f][i]);
            end
            for (i = int'(g_len[f]) - 1; i >= 0; i--) begin
                lr_stream.push_back(1'b1);
                d_stream.push_back(g_right_raw[f][i]);
            end
        end
    endtask

    // one bclk period, pins move on the falling bclk edge
    task automatic drive_bit(bit lr, bit d);
        bclk  = 1'b0;
        lrclk = lr;
        sdata = d;
        repeat (HALF_BCLK) @(negedge clk);
        bclk = 1'b1;
        repeat (HALF_BCLK) @(negedge clk);
    endtask

    // lrclk leads the data by one bclk, trailing periods close the last slot
    task automatic play_stream();
        int p;
        int total;
        bit lr;
        bit d;
        total = lr_stream.size();
        for (p = 0; p < total + 4; p++) begin
            lr = (p + 1 < total) ? lr_stream[p + 1] : 1'b0;
            d  = (p < total) ? d_stream[p] : 1'b0;
            drive_bit(lr, d);
        end
        bclk = 1'b0;
    endtask

    //////////////////////////////////////////////////
    // monitors
    //////////////////////////////////////////////////

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_limit > 0 && cycle_cnt > cycle_limit) begin
            stop_with_failure("timeout, the frames did not all come through in time");
        end
    end

    always @(negedge clk) begin
        if (rst_n) begin
            if (pcm_valid) begin
                if (frames_seen >= n_frames) begin
                    stop_with_failure("more pcm frames came out than the golden file holds");
                end
                check_frame(frames_seen, pcm, g_frame[frames_seen]);
                check_status(status, '{overrun: 1'b0, last_len: g_len[frames_seen]});
                duty_q.push_back({g_duty_l[frames_seen], g_duty_r[frames_seen]});
                frames_seen++;
            end
            // credit return marks counter 0 with the new duty
            if (UUT.credit_return) begin
                if (duty_q.size() == 0) begin
                    stop_with_failure("modulator popped a frame that was never sent");
                end
                duty_exp  = duty_q.pop_front();
                in_window = 1'b1;
                win_cnt   = 0;
                high_l    = 0;
                high_r    = 0;
            end
            if (in_window) begin
                high_l += int'(pwm_l);
                high_r += int'(pwm_r);
                win_cnt++;
                if (win_cnt == PERIOD_CLKS) begin
                    check_duty(duties_done, duty_exp[2*`PWM_W-1:`PWM_W],
                               duty_exp[`PWM_W-1:0], high_l, high_r);
                    in_window = 1'b0;
                    duties_done++;
                end
            end
        end
    end

    //////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////

    initial begin
        rst_n       = 1'b1;
        bclk        = 1'b0;
        lrclk       = 1'b0;
        sdata       = 1'b0;
        frames_seen = 0;
        duties_done = 0;
        in_window   = 1'b0;
        cycle_cnt   = 0;
        cycle_limit = 0;
        load_golden();
        build_stream();
        cycle_limit = n_frames * 2 * `SLOT_W * 2 * HALF_BCLK + MARGIN;
        #1 rst_n = 1'b0;
        repeat (16) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        // quiet after reset
        check_level("pcm_valid", pcm_valid, 1'b0);
        check_level("pwm_l", pwm_l, 1'b0);
        check_level("pwm_r", pwm_r, 1'b0);
        check_status(status, '0);
        play_stream();
        wait (duties_done == n_frames);
        if (frames_seen != n_frames) begin
            stop_with_failure("pcm frame count differs from the golden file");
        end else begin
            $display("Regression passed");
            $finish;
        end
    end

endmodule

// File: tests/i2s_pwm_golden.txt
# len left_raw right_raw left_pcm right_pcm duty_l duty_r
# all hex, raw words right aligned in the slot, len 20=32 18=24 10=16 14=20
20 7FFFFFFF 80000000 7FFFFF 800000 FF 00
20 00000000 00000000 000000 000000 80 80
20 12345678 EDCBA987 123456 EDCBA9 92 6D
20 80000000 7FFFFFFF 800000 7FFFFF 00 FF
18 00ABCDEF 00123456 ABCDEF 123456 2B 92
18 007FFFFF 00800001 7FFFFF 800001 FF 00
10 00007FFF 00008000 7FFF00 800000 FF 00
10 00001234 0000ABCD 123400 ABCD00 92 2B
10 00000000 0000FFFF 000000 FFFF00 80 7F
14 0007FFFF 00080000 7FFFF0 800000 FF 00
14 00012345 000FEDCB 123450 FEDCB0 92 7E
14 00000001 0003C3C3 000010 3C3C30 80 BC
20 C0000000 40000000 C00000 400000 40 C0
20 01020304 0A0B0C0D 010203 0A0B0C 81 8A
20 FFFFFFFF 00000100 FFFFFF 000001 7F 80
18 005A5A5A 00A5A5A5 5A5A5A A5A5A5 DA 25

// File: flist.f
+incdir+common
common/audio_pkg.sv
i2s_rx/i2s_rx.sv
i2s_rx/sample_aligner.sv
pwm/pwm_modulator.sv
src/i2s_pwm_top.sv
tests/i2s_pwm_sva.sv
tests/tb_i2s_pwm.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only --timing --assert
TOP       ?= tb_i2s_pwm
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := Regression passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FLIST)

$(OBJ_DIR)/V$(TOP): $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

# pass only if the pass message shows up in the output
sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
